// File: design/umode_defines.svh
/* Widths, CSR field positions, instruction encodings and the register map of the
   user-mode privilege monitor; included by the packages and the RTL */
`ifndef UMODE_DEFINES_SVH
`define UMODE_DEFINES_SVH

`define UMODE_XLEN        32
`define UMODE_NUM_RULES   8
`define UMODE_COUNT_W     16
`define UMODE_WB_ADDR_W   4

// mstatus fields
`define UMODE_MPP_POS     11
`define UMODE_MPRV_POS    17
`define UMODE_TW_POS      21

// misa extension letters
`define UMODE_MISA_U_POS  20
`define UMODE_MISA_S_POS  18
`define UMODE_MISA_N_POS  13

`define UMODE_MODE_U      2'b00
`define UMODE_MODE_M      2'b11

// Whole instruction words
`define UMODE_MRET_INSN     32'h3020_0073
`define UMODE_WFI_INSN      32'h1050_0073
`define UMODE_URET_INSN     32'h0020_0073
`define UMODE_CUSTOM0_INSN  32'h8C00_0073
`define UMODE_CUSTOM1_INSN  32'hCC00_0073
`define UMODE_CUSTOM_MASK   32'hFC00_707F
`define UMODE_SYSTEM_OPCODE 7'b111_0011

// N-extension and delegation CSRs, none of which exist here
`define UMODE_CSR_USTATUS   12'h000
`define UMODE_CSR_UIE       12'h004
`define UMODE_CSR_UTVEC     12'h005
`define UMODE_CSR_USCRATCH  12'h040
`define UMODE_CSR_UEPC      12'h041
`define UMODE_CSR_UCAUSE    12'h042
`define UMODE_CSR_UTVAL     12'h043
`define UMODE_CSR_UIP       12'h044
`define UMODE_CSR_MEDELEG   12'h302
`define UMODE_CSR_MIDELEG   12'h303

`define UMODE_EXC_ILLEGAL          6'd2
`define UMODE_EXC_INSTR_FAULT      6'd1
`define UMODE_EXC_INSTR_BUS_FAULT  6'd48
`define UMODE_DBG_TRIGGER          3'd2

// Addresses 0..7 hold the per-rule counters
`define UMODE_REG_STICKY  4'd8

`endif

// File: design/riscv_priv_pkg.sv
/* ISA-side types shared by the trace ports and the decoder */
package riscv_priv_pkg;

`include "umode_defines.svh"

  // Privilege level, encoded as in mstatus.MPP
  typedef logic [1:0] priv_mode_t;

  typedef logic [31:0] insn_t;

  // CSR value as seen on the trace
  typedef logic [`UMODE_XLEN-1:0] xlen_word_t;

  typedef logic [11:0] csr_addr_t;

  // Synchronous exception cause, low bits of mcause
  typedef logic [5:0] exc_cause_t;

  // dcsr.cause style debug entry reason
  typedef logic [2:0] dbg_cause_t;

endpackage

// File: design/umode_mon_pkg.sv
/* Monitor-side types: rule vectors, violation counters and the Wishbone view */
package umode_mon_pkg;

`include "umode_defines.svh"

  // One bit per rule, bit index is the rule number
  typedef logic [`UMODE_NUM_RULES-1:0] rule_vec_t;

  typedef logic [`UMODE_COUNT_W-1:0] viol_count_t;

  typedef logic [`UMODE_WB_ADDR_W-1:0] wb_addr_t;
  typedef logic [`UMODE_XLEN-1:0]      wb_data_t;

  typedef enum logic {
    WB_IDLE,
    WB_ACK
  } wb_state_t;

endpackage

// File: design/rvfi_decode.sv
/* First pipeline stage: samples one retirement record per cycle and
   registers its instruction class, trap status and CSR summaries */
`timescale 1ns/1ns
`include "umode_defines.svh"

module rvfi_decode
  import riscv_priv_pkg::*;
(
  input  logic       clk_i,
  input  logic       rst,

  input  logic       rvfi_valid,
  input  priv_mode_t rvfi_mode,
  input  insn_t      rvfi_insn,
  input  logic       rvfi_dbg_mode,
  input  logic       rvfi_intr,
  input  logic       rvfi_trap,
  input  logic       rvfi_trap_exception,
  input  exc_cause_t rvfi_trap_exc_cause,
  input  logic       rvfi_trap_debug,
  input  dbg_cause_t rvfi_trap_dbg_cause,
  input  xlen_word_t csr_misa_rdata,
  input  xlen_word_t csr_mstatus_rdata,
  input  xlen_word_t csr_mstatus_wdata,
  input  xlen_word_t csr_mstatus_wmask,
  input  xlen_word_t csr_mscratch_wmask,

  output logic       dec_valid,
  output priv_mode_t dec_mode,
  output logic       dec_dbg_mode,
  output logic       dec_intr,
  output logic       dec_trap,
  output logic       dec_is_mret,
  output logic       dec_is_wfi,
  output logic       dec_is_custom,
  output logic       dec_is_uret,
  output logic       dec_is_csr,
  output csr_addr_t  dec_csr_addr,
  output logic       dec_illegal,
  output logic       dec_misa_ok,
  output logic       dec_tw,
  output priv_mode_t dec_mpp_pre,
  output priv_mode_t dec_mpp_post,
  output logic       dec_mscratch_written
);

  logic       fetch_fault;
  logic       trig_hit;
  logic       insn_ok;
  logic       is_system;
  xlen_word_t mstatus_post;

  // Revoked fetches and trigger hits never executed the instruction
  assign fetch_fault = rvfi_trap_exception &&
                       ((rvfi_trap_exc_cause == `UMODE_EXC_INSTR_FAULT) ||
                        (rvfi_trap_exc_cause == `UMODE_EXC_INSTR_BUS_FAULT));
  assign trig_hit    = rvfi_trap && rvfi_trap_debug &&
                       (rvfi_trap_dbg_cause == `UMODE_DBG_TRIGGER);
  assign insn_ok     = rvfi_valid && !fetch_fault && !trig_hit;

  assign is_system   = (rvfi_insn[6:0] == `UMODE_SYSTEM_OPCODE);

  // Written bits come from wdata, the rest keep their old value
  assign mstatus_post = (csr_mstatus_wdata & csr_mstatus_wmask) |
                        (csr_mstatus_rdata & ~csr_mstatus_wmask);

  always_ff @(posedge clk_i) begin
    if (rst) begin
      dec_valid <= 1'b0;
    end else begin
      dec_valid <= rvfi_valid;
    end
  end

  always_ff @(posedge clk_i) begin
    dec_mode      <= rvfi_mode;
    dec_dbg_mode  <= rvfi_dbg_mode;
    dec_intr      <= rvfi_intr;
    dec_trap      <= rvfi_trap;
    dec_is_mret   <= insn_ok && (rvfi_insn == `UMODE_MRET_INSN);
    dec_is_wfi    <= insn_ok && (rvfi_insn == `UMODE_WFI_INSN);
    dec_is_uret   <= insn_ok && (rvfi_insn == `UMODE_URET_INSN);
    dec_is_custom <= insn_ok &&
                     (((rvfi_insn & `UMODE_CUSTOM_MASK) == `UMODE_CUSTOM0_INSN) ||
                      ((rvfi_insn & `UMODE_CUSTOM_MASK) == `UMODE_CUSTOM1_INSN));
    // funct3 of 0 and 4 are not Zicsr
    dec_is_csr    <= insn_ok && is_system &&
                     (rvfi_insn[14:12] != 3'b000) && (rvfi_insn[14:12] != 3'b100);
    dec_csr_addr  <= rvfi_insn[31:20];
    dec_illegal   <= rvfi_trap && rvfi_trap_exception &&
                     (rvfi_trap_exc_cause == `UMODE_EXC_ILLEGAL);
    dec_misa_ok   <= csr_misa_rdata[`UMODE_MISA_U_POS] &&
                     !csr_misa_rdata[`UMODE_MISA_S_POS] &&
                     !csr_misa_rdata[`UMODE_MISA_N_POS];
    dec_tw        <= csr_mstatus_rdata[`UMODE_TW_POS];
    dec_mpp_pre   <= csr_mstatus_rdata[`UMODE_MPP_POS +: $bits(priv_mode_t)];
    dec_mpp_post  <= mstatus_post[`UMODE_MPP_POS +: $bits(priv_mode_t)];
    dec_mscratch_written <= |csr_mscratch_wmask;
  end

endmodule

// File: design/umode_rule_check.sv
/* Second stage: applies the eight privilege rules to each decoded retirement
   and keeps the trap and MRET history needed by the sequential rules */
`timescale 1ns/1ns
`include "umode_defines.svh"

module umode_rule_check
  import riscv_priv_pkg::*;
  import umode_mon_pkg::*;
(
  input  logic       clk_i,
  input  logic       rst,

  input  logic       dec_valid,
  input  priv_mode_t dec_mode,
  input  logic       dec_dbg_mode,
  input  logic       dec_intr,
  input  logic       dec_trap,
  input  logic       dec_is_mret,
  input  logic       dec_is_wfi,
  input  logic       dec_is_custom,
  input  logic       dec_is_uret,
  input  logic       dec_is_csr,
  input  csr_addr_t  dec_csr_addr,
  input  logic       dec_illegal,
  input  logic       dec_misa_ok,
  input  logic       dec_tw,
  input  priv_mode_t dec_mpp_pre,
  input  priv_mode_t dec_mpp_post,
  input  logic       dec_mscratch_written,

  output rule_vec_t  violations
);

  logic       in_umode;
  logic       in_mmode;
  logic       csr_absent;
  logic       trap_pend;
  logic       mret_pend;
  priv_mode_t mret_mpp;
  rule_vec_t  hits;

  assign in_umode = (dec_mode == `UMODE_MODE_U);
  assign in_mmode = (dec_mode == `UMODE_MODE_M);

  // CSRs that are illegal from any mode
  always_comb begin
    case (dec_csr_addr)
      `UMODE_CSR_USTATUS, `UMODE_CSR_UIE, `UMODE_CSR_UTVEC, `UMODE_CSR_USCRATCH,
      `UMODE_CSR_UEPC, `UMODE_CSR_UCAUSE, `UMODE_CSR_UTVAL, `UMODE_CSR_UIP,
      `UMODE_CSR_MEDELEG, `UMODE_CSR_MIDELEG: csr_absent = 1'b1;
      default: csr_absent = 1'b0;
    endcase
  end

  always_comb begin
    hits    = '0;
    hits[0] = !dec_misa_ok;
    hits[1] = !(in_umode || in_mmode) || (dec_dbg_mode && !in_mmode);
    hits[2] = in_umode && dec_mscratch_written;
    hits[3] = (dec_mpp_post != `UMODE_MODE_U) && (dec_mpp_post != `UMODE_MODE_M);
    // Trap handler must run in M
    hits[4] = trap_pend && !in_mmode;
    // WFI legality follows TW exactly in U mode
    hits[5] = (dec_is_wfi && in_umode && (dec_tw != dec_illegal)) ||
              ((dec_is_custom || dec_is_uret || (dec_is_mret && in_umode)) &&
               !dec_illegal);
    // Insn bits 29:28 are the CSR privilege field
    hits[6] = dec_is_csr && !dec_illegal &&
              ((in_umode && (dec_csr_addr[9:8] != 2'b00)) || csr_absent);
    hits[7] = mret_pend && !dec_intr && (dec_mode != mret_mpp);
  end

  // History of the previous valid retirement
  always_ff @(posedge clk_i) begin
    if (rst) begin
      trap_pend <= 1'b0;
      mret_pend <= 1'b0;
    end else if (dec_valid) begin
      trap_pend <= dec_trap;
      mret_pend <= dec_is_mret && in_mmode && !dec_dbg_mode && !dec_trap;
    end
  end

  always_ff @(posedge clk_i) begin
    if (dec_valid) begin
      mret_mpp <= dec_mpp_pre;
    end
  end

  always_ff @(posedge clk_i) begin
    if (rst) begin
      violations <= '0;
    end else begin
      violations <= dec_valid ? hits : '0;
    end
  end

endmodule

// File: design/rule_counter.sv
/* Violation counter for one rule, saturating, with a sticky flag that
   holds until the register block clears it */
`timescale 1ns/1ns

module rule_counter
  import umode_mon_pkg::*;
(
  input  logic        clk_i,
  input  logic        rst,
  input  logic        hit,
  input  logic        clear,
  output viol_count_t count,
  output logic        sticky
);

  // Clear has priority over a hit in the same cycle
  always_ff @(posedge clk_i) begin
    if (rst || clear) begin
      count  <= '0;
      sticky <= 1'b0;
    end else if (hit) begin
      if (count != '1) begin
        count <= count + 1'b1;
      end
      sticky <= 1'b1;
    end
  end

endmodule

// File: design/wb_status_regs.sv
/* Wishbone classic slave that reads out the violation counters and the sticky
   vector; a write to the sticky register clears the rules selected by its data */
`timescale 1ns/1ns
`include "umode_defines.svh"

module wb_status_regs
  import umode_mon_pkg::*;
(
  input  logic        clk_i,
  input  logic        rst,

  input  logic        wb_cyc,
  input  logic        wb_stb,
  input  logic        wb_we,
  input  wb_addr_t    wb_adr,
  input  wb_data_t    wb_dat_w,
  output wb_data_t    wb_dat_r,
  output logic        wb_ack,

  input  viol_count_t [`UMODE_NUM_RULES-1:0] counts,
  input  rule_vec_t   stickies,
  output rule_vec_t   clear,
  output logic        violation
);

  localparam int RuleIdxW = $clog2(`UMODE_NUM_RULES);

  wb_state_t state;
  wb_data_t  rd_data;
  logic      req;

  assign req = wb_cyc && wb_stb;

  // Address decode for reads
  always_comb begin
    rd_data = '0;
    if (wb_adr < `UMODE_NUM_RULES) begin
      rd_data[`UMODE_COUNT_W-1:0] = counts[wb_adr[RuleIdxW-1:0]];
    end else if (wb_adr == `UMODE_REG_STICKY) begin
      rd_data[`UMODE_NUM_RULES-1:0] = stickies;
    end
  end

  always_ff @(posedge clk_i) begin
    if (rst) begin
      state <= WB_IDLE;
      clear <= '0;
    end else begin
      clear <= '0;
      case (state)
        WB_IDLE: begin
          if (req) begin
            state <= WB_ACK;
            if (wb_we && (wb_adr == `UMODE_REG_STICKY)) begin
              clear <= wb_dat_w[`UMODE_NUM_RULES-1:0];
            end
          end
        end
        default: state <= WB_IDLE;
      endcase
    end
  end

  // Data is captured on the edge that raises ack
  always_ff @(posedge clk_i) begin
    if ((state == WB_IDLE) && req) begin
      wb_dat_r <= rd_data;
    end
  end

  assign wb_ack    = (state == WB_ACK);
  assign violation = |stickies;

endmodule

// File: design/umode_monitor_top.sv
/* Top level of the user-mode privilege monitor: trace in, decode, rule check,
   per-rule counters and the Wishbone status registers */
`timescale 1ns/1ns
`include "umode_defines.svh"

module umode_monitor_top
  import riscv_priv_pkg::*;
  import umode_mon_pkg::*;
(
  input  logic       clk_i,
  input  logic       rst,

  input  logic       rvfi_valid,
  input  priv_mode_t rvfi_mode,
  input  insn_t      rvfi_insn,
  input  logic       rvfi_dbg_mode,
  input  logic       rvfi_intr,
  input  logic       rvfi_trap,
  input  logic       rvfi_trap_exception,
  input  exc_cause_t rvfi_trap_exc_cause,
  input  logic       rvfi_trap_debug,
  input  dbg_cause_t rvfi_trap_dbg_cause,
  input  xlen_word_t csr_misa_rdata,
  input  xlen_word_t csr_mstatus_rdata,
  input  xlen_word_t csr_mstatus_wdata,
  input  xlen_word_t csr_mstatus_wmask,
  input  xlen_word_t csr_mscratch_wmask,

  input  logic       wb_cyc,
  input  logic       wb_stb,
  input  logic       wb_we,
  input  wb_addr_t   wb_adr,
  input  wb_data_t   wb_dat_w,
  output wb_data_t   wb_dat_r,
  output logic       wb_ack,

  output logic       violation
);

  logic        dec_valid;
  priv_mode_t  dec_mode;
  logic        dec_dbg_mode;
  logic        dec_intr;
  logic        dec_trap;
  logic        dec_is_mret;
  logic        dec_is_wfi;
  logic        dec_is_custom;
  logic        dec_is_uret;
  logic        dec_is_csr;
  csr_addr_t   dec_csr_addr;
  logic        dec_illegal;
  logic        dec_misa_ok;
  logic        dec_tw;
  priv_mode_t  dec_mpp_pre;
  priv_mode_t  dec_mpp_post;
  logic        dec_mscratch_written;

  rule_vec_t   violations;
  rule_vec_t   stickies;
  rule_vec_t   clear;
  viol_count_t [`UMODE_NUM_RULES-1:0] counts;

  rvfi_decode u_decode (
    .clk_i, .rst,
    .rvfi_valid, .rvfi_mode, .rvfi_insn, .rvfi_dbg_mode, .rvfi_intr,
    .rvfi_trap, .rvfi_trap_exception, .rvfi_trap_exc_cause,
    .rvfi_trap_debug, .rvfi_trap_dbg_cause,
    .csr_misa_rdata, .csr_mstatus_rdata, .csr_mstatus_wdata,
    .csr_mstatus_wmask, .csr_mscratch_wmask,
    .dec_valid, .dec_mode, .dec_dbg_mode, .dec_intr, .dec_trap,
    .dec_is_mret, .dec_is_wfi, .dec_is_custom, .dec_is_uret, .dec_is_csr,
    .dec_csr_addr, .dec_illegal, .dec_misa_ok, .dec_tw,
    .dec_mpp_pre, .dec_mpp_post, .dec_mscratch_written
  );

  umode_rule_check u_rule_check (
    .clk_i, .rst,
    .dec_valid, .dec_mode, .dec_dbg_mode, .dec_intr, .dec_trap,
    .dec_is_mret, .dec_is_wfi, .dec_is_custom, .dec_is_uret, .dec_is_csr,
    .dec_csr_addr, .dec_illegal, .dec_misa_ok, .dec_tw,
    .dec_mpp_pre, .dec_mpp_post, .dec_mscratch_written,
    .violations
  );

  // One counter per rule
  for (genvar i = 0; i < `UMODE_NUM_RULES; i++) begin : gen_rules
    rule_counter u_counter (
      .clk_i  (clk_i),
      .rst    (rst),
      .hit    (violations[i]),
      .clear  (clear[i]),
      .count  (counts[i]),
      .sticky (stickies[i])
    );
  end

  wb_status_regs u_regs (
    .clk_i, .rst,
    .wb_cyc, .wb_stb, .wb_we, .wb_adr, .wb_dat_w, .wb_dat_r, .wb_ack,
    .counts, .stickies, .clear, .violation
  );

endmodule

// File: testbench/umode_checker.sv
/* Reference model of the eight privilege rules; watches the trace and the Wishbone
   bus of the monitor and compares every register read against its own counters */
`timescale 1ns/1ns
`include "umode_defines.svh"

module umode_checker
  import riscv_priv_pkg::*;
  import umode_mon_pkg::*;
(
  input  logic       clk_i,
  input  logic       rst,
  input  logic       rvfi_valid,
  input  priv_mode_t rvfi_mode,
  input  insn_t      rvfi_insn,
  input  logic       rvfi_dbg_mode,
  input  logic       rvfi_intr,
  input  logic       rvfi_trap,
  input  logic       rvfi_trap_exception,
  input  exc_cause_t rvfi_trap_exc_cause,
  input  logic       rvfi_trap_debug,
  input  dbg_cause_t rvfi_trap_dbg_cause,
  input  xlen_word_t csr_misa_rdata,
  input  xlen_word_t csr_mstatus_rdata,
  input  xlen_word_t csr_mstatus_wdata,
  input  xlen_word_t csr_mstatus_wmask,
  input  xlen_word_t csr_mscratch_wmask,
  input  logic       wb_cyc,
  input  logic       wb_stb,
  input  logic       wb_we,
  input  wb_addr_t   wb_adr,
  input  wb_data_t   wb_dat_w,
  input  wb_data_t   wb_dat_r,
  input  logic       wb_ack,
  input  logic       violation,
  output int         error_count
);

  string       test_name = "none";
  int          errors = 0;
  viol_count_t cnt [0:7];
  rule_vec_t   sticky;
  logic        trap_pend;
  logic        mret_pend;
  priv_mode_t  saved_mpp;
  logic        prev_ack;

  assign error_count = errors;

  // N-extension CSRs and the delegation registers do not exist
  function automatic logic csr_missing(input csr_addr_t a);
    case (a)
      12'h000, 12'h004, 12'h005, 12'h040, 12'h041, 12'h042, 12'h043, 12'h044,
      12'h302, 12'h303: return 1'b1;
      default: return 1'b0;
    endcase
  endfunction

  always @(posedge clk_i) begin
    logic       excl;
    logic       is_u;
    logic       is_m;
    logic       ill;
    logic       k_mret;
    logic       k_wfi;
    logic       k_other;
    logic       k_csr;
    xlen_word_t post;
    priv_mode_t mpp;
    rule_vec_t  hit;
    wb_data_t   expected;
    if (rst) begin
      for (int i = 0; i < 8; i++) begin
        cnt[i] = '0;
      end
      sticky    = '0;
      trap_pend = 1'b0;
      mret_pend = 1'b0;
      saved_mpp = `UMODE_MODE_M;
      prev_ack  = 1'b0;
    end else begin
      if (rvfi_valid) begin
        excl = (rvfi_trap_exception && (rvfi_trap_exc_cause == 6'd1 ||
                                        rvfi_trap_exc_cause == 6'd48)) ||
               (rvfi_trap && rvfi_trap_debug && rvfi_trap_dbg_cause == 3'd2);
        is_u    = (rvfi_mode == 2'b00);
        is_m    = (rvfi_mode == 2'b11);
        ill     = rvfi_trap && rvfi_trap_exception && (rvfi_trap_exc_cause == 6'd2);
        k_mret  = !excl && (rvfi_insn == 32'h3020_0073);
        k_wfi   = !excl && (rvfi_insn == 32'h1050_0073);
        k_other = !excl && ((rvfi_insn == 32'h0020_0073) ||
                            ((rvfi_insn & 32'hFC00_707F) == 32'h8C00_0073) ||
                            ((rvfi_insn & 32'hFC00_707F) == 32'hCC00_0073));
        k_csr   = !excl && (rvfi_insn[6:0] == 7'h73) &&
                  (rvfi_insn[14:12] != 3'd0) && (rvfi_insn[14:12] != 3'd4);
        post = (csr_mstatus_wdata & csr_mstatus_wmask) |
               (csr_mstatus_rdata & ~csr_mstatus_wmask);
        mpp  = post[12:11];
        hit    = '0;
        hit[0] = !csr_misa_rdata[20] || csr_misa_rdata[18] || csr_misa_rdata[13];
        hit[1] = !(is_u || is_m) || (rvfi_dbg_mode && !is_m);
        hit[2] = is_u && (csr_mscratch_wmask != '0);
        hit[3] = (mpp == 2'b01) || (mpp == 2'b10);
        hit[4] = trap_pend && !is_m;
        // URET counts with the custom ones, MRET only from U
        hit[5] = (k_wfi && is_u && (csr_mstatus_rdata[21] != ill)) ||
                 ((k_other || (k_mret && is_u)) && !ill);
        hit[6] = k_csr && !ill &&
                 ((is_u && rvfi_insn[29:28] != 2'b00) || csr_missing(rvfi_insn[31:20]));
        hit[7] = mret_pend && !rvfi_intr && (rvfi_mode != saved_mpp);
        for (int i = 0; i < 8; i++) begin
          if (hit[i]) begin
            if (cnt[i] != 16'hFFFF) begin
              cnt[i] = cnt[i] + 1'b1;
            end
            sticky[i] = 1'b1;
          end
        end
        trap_pend = rvfi_trap;
        mret_pend = k_mret && is_m && !rvfi_dbg_mode && !rvfi_trap;
        saved_mpp = csr_mstatus_rdata[12:11];
      end
      // Ack answers a held request and lasts a single cycle
      if (wb_ack && !(wb_cyc && wb_stb)) begin
        $display("%s: Wishbone ack without a pending request", test_name);
        errors++;
      end
      if (wb_ack && prev_ack) begin
        $display("%s: Wishbone ack held for more than one cycle", test_name);
        errors++;
      end
      prev_ack = wb_ack;
      if (wb_ack && wb_we && (wb_adr == 4'd8)) begin
        for (int i = 0; i < 8; i++) begin
          if (wb_dat_w[i]) begin
            cnt[i]    = '0;
            sticky[i] = 1'b0;
          end
        end
      end else if (wb_ack && !wb_we) begin
        expected = '0;
        if (wb_adr < 4'd8) begin
          expected[15:0] = cnt[wb_adr[2:0]];
        end else if (wb_adr == 4'd8) begin
          expected[7:0] = sticky;
        end
        if (wb_dat_r !== expected) begin
          $display("Error %s: register %0d expected %h actual %h",
                   test_name, wb_adr, expected, wb_dat_r);
          errors++;
        end
        if (violation !== (|sticky)) begin
          $display("Error %s: violation expected %b actual %b",
                   test_name, |sticky, violation);
          errors++;
        end
      end
    end
  end

endmodule

// File: testbench/tb_umode_monitor.sv
/* Testbench for the privilege monitor: crafted and random retirement records,
   Wishbone reads and clears, one result line per test and a summary */
`timescale 1ns/1ns
`include "umode_defines.svh"

module tb_umode_monitor
  import riscv_priv_pkg::*;
  import umode_mon_pkg::*;
();

  localparam int         NumRecords   = 400;
  localparam int         NumReads     = 100;
  localparam int         NumTests     = 5;
  localparam xlen_word_t GoodMisa     = 32'h4010_0100;
  localparam xlen_word_t MstatusMppM  = 32'h0000_1800;
  localparam insn_t      NopInsn      = 32'h0000_0013;
  localparam insn_t      CsrrsMstatus = 32'h3000_2073;

  logic       clk_i;
  logic       rst;
  logic       rvfi_valid;
  priv_mode_t rvfi_mode;
  insn_t      rvfi_insn;
  logic       rvfi_dbg_mode;
  logic       rvfi_intr;
  logic       rvfi_trap;
  logic       rvfi_trap_exception;
  exc_cause_t rvfi_trap_exc_cause;
  logic       rvfi_trap_debug;
  dbg_cause_t rvfi_trap_dbg_cause;
  xlen_word_t csr_misa_rdata;
  xlen_word_t csr_mstatus_rdata;
  xlen_word_t csr_mstatus_wdata;
  xlen_word_t csr_mstatus_wmask;
  xlen_word_t csr_mscratch_wmask;
  logic       wb_cyc;
  logic       wb_stb;
  logic       wb_we;
  wb_addr_t   wb_adr;
  wb_data_t   wb_dat_w;
  wb_data_t   wb_dat_r;
  logic       wb_ack;
  logic       violation;
  int         error_count;

  logic [31:0] lfsr = 32'he13356cd;
  wb_data_t    regs [0:8];
  string       cur_name;
  int          local_errors = 0;
  int          errs_at_start;
  int          passed = 0;
  int          failed = 0;

  umode_monitor_top u_dut (.*);
  umode_checker u_checker (.*);

  initial begin
    clk_i = 1'b0;
    forever #5 clk_i = ~clk_i;
  end

  // Galois LFSR, one step per bit taken
  function automatic logic [31:0] rand_bits(input int n);
    logic [31:0] r;
    logic        b;
    r = '0;
    for (int i = 0; i < n; i++) begin
      b    = lfsr[0];
      lfsr = (lfsr >> 1) ^ (b ? 32'h8020_0003 : 32'h0);
      r    = {r[30:0], b};
    end
    return r;
  endfunction

  // Legal M-mode NOP with nothing written
  task automatic load_benign();
    rvfi_valid          <= 1'b1;
    rvfi_mode           <= `UMODE_MODE_M;
    rvfi_insn           <= NopInsn;
    rvfi_dbg_mode       <= 1'b0;
    rvfi_intr           <= 1'b0;
    rvfi_trap           <= 1'b0;
    rvfi_trap_exception <= 1'b0;
    rvfi_trap_exc_cause <= '0;
    rvfi_trap_debug     <= 1'b0;
    rvfi_trap_dbg_cause <= '0;
    csr_misa_rdata      <= GoodMisa;
    csr_mstatus_rdata   <= MstatusMppM;
    csr_mstatus_wdata   <= '0;
    csr_mstatus_wmask   <= '0;
    csr_mscratch_wmask  <= '0;
  endtask

  task automatic next_record();
    @(posedge clk_i);
    load_benign();
  endtask

  task automatic go_idle(input int n);
    @(posedge clk_i);
    rvfi_valid <= 1'b0;
    repeat (n) @(posedge clk_i);
  endtask

  task automatic load_random();
    logic [31:0] r;
    logic [31:0] csr_list [0:7];
    xlen_word_t  mst;
    csr_list = '{32'h300, 32'h340, 32'h000, 32'h044, 32'h302, 32'h303, 32'hC00, 32'h001};
    r = rand_bits(2);
    rvfi_mode <= r[1:0];
    r = rand_bits(3);
    case (r[2:0])
      3'd1: rvfi_insn <= `UMODE_MRET_INSN;
      3'd2: rvfi_insn <= `UMODE_WFI_INSN;
      3'd3: rvfi_insn <= `UMODE_URET_INSN;
      3'd4: rvfi_insn <= `UMODE_CUSTOM0_INSN | (rand_bits(32) & ~`UMODE_CUSTOM_MASK);
      3'd5: rvfi_insn <= `UMODE_CUSTOM1_INSN | (rand_bits(32) & ~`UMODE_CUSTOM_MASK);
      3'd6: begin
        r = rand_bits(6);
        rvfi_insn <= {csr_list[r[2:0]][11:0], 5'd0, r[5], (r[4:3] == 2'b00) ? 2'b01 : r[4:3],
                      5'd1, 7'h73};
      end
      3'd7: rvfi_insn <= rand_bits(32);
      default: rvfi_insn <= NopInsn;
    endcase
    r = rand_bits(2);
    if (r[1:0] == 2'b00) begin
      rvfi_trap <= 1'b1;
      r = rand_bits(3);
      if (!r[2]) begin
        rvfi_trap_exception <= 1'b1;
        case (r[1:0])
          2'd0: rvfi_trap_exc_cause <= `UMODE_EXC_ILLEGAL;
          2'd1: rvfi_trap_exc_cause <= `UMODE_EXC_INSTR_FAULT;
          2'd2: rvfi_trap_exc_cause <= `UMODE_EXC_INSTR_BUS_FAULT;
          default: rvfi_trap_exc_cause <= 6'd3;
        endcase
      end else begin
        rvfi_trap_debug     <= 1'b1;
        rvfi_trap_dbg_cause <= r[0] ? `UMODE_DBG_TRIGGER : 3'd1;
      end
    end
    r = rand_bits(3);
    rvfi_intr <= (r[2:0] == 3'd0);
    r = rand_bits(3);
    rvfi_dbg_mode <= (r[2:0] == 3'd0);
    r = rand_bits(3);
    if (r[2:0] == 3'd0) begin
      csr_misa_rdata <= GoodMisa | (32'h1 << `UMODE_MISA_S_POS);
    end else if (r[2:0] == 3'd1) begin
      csr_misa_rdata <= GoodMisa | (32'h1 << `UMODE_MISA_N_POS);
    end
    r = rand_bits(6);
    mst = '0;
    mst[`UMODE_TW_POS] = r[0];
    mst[`UMODE_MPP_POS +: 2] = r[2:1];
    csr_mstatus_rdata <= mst;
    csr_mstatus_wmask <= r[3] ? MstatusMppM : 32'h0;
    csr_mstatus_wdata <= {19'h0, r[5:4], 11'h0};
    r = rand_bits(3);
    csr_mscratch_wmask <= (r[2:0] == 3'd0) ? 32'h1 : 32'h0;
  endtask

  // One crafted record, or a pair for the sequential rules
  task automatic send_violation(input int rule);
    next_record();
    case (rule)
      0: csr_misa_rdata <= GoodMisa | (32'h1 << `UMODE_MISA_S_POS);
      1: rvfi_mode <= 2'b01;
      2: begin
        rvfi_mode          <= `UMODE_MODE_U;
        csr_mscratch_wmask <= 32'h1;
      end
      3: begin
        csr_mstatus_wmask <= MstatusMppM;
        csr_mstatus_wdata <= 32'h0000_0800;
      end
      4: begin
        rvfi_trap           <= 1'b1;
        rvfi_trap_exception <= 1'b1;
        rvfi_trap_exc_cause <= `UMODE_EXC_ILLEGAL;
        next_record();
        rvfi_mode <= `UMODE_MODE_U;
      end
      5: begin
        rvfi_mode <= `UMODE_MODE_U;
        rvfi_insn <= `UMODE_URET_INSN;
      end
      6: begin
        rvfi_mode <= `UMODE_MODE_U;
        rvfi_insn <= CsrrsMstatus;
      end
      default: begin
        rvfi_insn         <= `UMODE_MRET_INSN;
        csr_mstatus_rdata <= '0;
        next_record();
      end
    endcase
    go_idle(4);
  endtask

  task automatic wb_xfer(input logic we, input wb_addr_t adr, input wb_data_t wdata,
                         output wb_data_t rdata);
    int waited;
    waited = 0;
    @(posedge clk_i);
    wb_cyc   <= 1'b1;
    wb_stb   <= 1'b1;
    wb_we    <= we;
    wb_adr   <= adr;
    wb_dat_w <= wdata;
    @(posedge clk_i);
    while (!wb_ack && waited < 16) begin
      @(posedge clk_i);
      waited++;
    end
    if (!wb_ack) begin
      $display("%s: no Wishbone ack for address %0d", cur_name, adr);
      local_errors++;
    end
    rdata = wb_dat_r;
    wb_cyc <= 1'b0;
    wb_stb <= 1'b0;
    wb_we  <= 1'b0;
  endtask

  task automatic wb_write(input wb_addr_t adr, input wb_data_t wdata);
    wb_data_t unused;
    wb_xfer(1'b1, adr, wdata, unused);
  endtask

  task automatic read_all();
    for (int a = 0; a < 9; a++) begin
      wb_xfer(1'b0, a[3:0], '0, regs[a]);
    end
  endtask

  task automatic check_value(input string what, input wb_data_t expected,
                             input wb_data_t actual);
    if (actual !== expected) begin
      $display("Error %s: %s expected %h actual %h", cur_name, what, expected, actual);
      local_errors++;
    end
  endtask

  task automatic start_test(input string name);
    cur_name              = name;
    u_checker.test_name   = name;
    errs_at_start         = error_count + local_errors;
  endtask

  task automatic end_test();
    int n;
    // Let the checker finish the compare of the last read
    @(negedge clk_i);
    n = error_count + local_errors - errs_at_start;
    if (n == 0) begin
      $display("%s: PASS", cur_name);
      passed++;
    end else begin
      $display("%s: FAIL with %0d errors", cur_name, n);
      failed++;
    end
  endtask

  initial begin
    #((NumRecords + NumReads + 20) * 10 * NumTests);
    $display("Watchdog expired before the tests finished");
    $display("Something failed");
    $finish;
  end

  initial begin
    logic [31:0] r;
    wb_data_t    rd;
    wb_data_t    mask;
    wb_data_t    prev_sticky;
    rst      <= 1'b1;
    wb_cyc   <= 1'b0;
    wb_stb   <= 1'b0;
    wb_we    <= 1'b0;
    wb_adr   <= '0;
    wb_dat_w <= '0;
    load_benign();
    rvfi_valid <= 1'b0;
    repeat (8) @(posedge clk_i);
    rst <= 1'b0;

    start_test("reset_values");
    read_all();
    check_value("violation", '0, {31'b0, violation});
    end_test();

    start_test("single_rules");
    for (int rule = 0; rule < 8; rule++) begin
      wb_write(`UMODE_REG_STICKY, 32'hFF);
      send_violation(rule);
      read_all();
      check_value($sformatf("rule %0d sticky", rule), 32'h1 << rule, regs[8]);
      check_value($sformatf("rule %0d count", rule), 32'h1, regs[rule]);
    end
    end_test();

    start_test("random_burst");
    for (int i = 0; i < NumRecords; i++) begin
      next_record();
      load_random();
    end
    go_idle(4);
    // Unmapped write and read
    wb_write(4'd5, 32'hFFFF_FFFF);
    wb_xfer(1'b0, 4'hF, '0, rd);
    read_all();
    end_test();

    start_test("clear_w1c");
    r           = rand_bits(8);
    mask        = {24'h0, r[7:0]};
    prev_sticky = regs[8];
    wb_write(`UMODE_REG_STICKY, mask);
    read_all();
    check_value("sticky", prev_sticky & ~mask, regs[8]);
    wb_write(`UMODE_REG_STICKY, 32'hFF);
    read_all();
    check_value("sticky", '0, regs[8]);
    check_value("violation", '0, {31'b0, violation});
    end_test();

    start_test("excluded_records");
    // Interrupted M-mode record ends any trap or MRET left pending
    next_record();
    rvfi_intr           <= 1'b1;
    next_record();
    rvfi_mode           <= `UMODE_MODE_U;
    rvfi_insn           <= `UMODE_URET_INSN;
    rvfi_trap           <= 1'b1;
    rvfi_trap_exception <= 1'b1;
    rvfi_trap_exc_cause <= `UMODE_EXC_INSTR_FAULT;
    next_record();
    next_record();
    rvfi_mode           <= `UMODE_MODE_U;
    rvfi_insn           <= CsrrsMstatus;
    rvfi_trap           <= 1'b1;
    rvfi_trap_debug     <= 1'b1;
    rvfi_trap_dbg_cause <= `UMODE_DBG_TRIGGER;
    next_record();
    next_record();
    rvfi_insn           <= `UMODE_CUSTOM0_INSN;
    rvfi_trap           <= 1'b1;
    rvfi_trap_exception <= 1'b1;
    rvfi_trap_exc_cause <= `UMODE_EXC_INSTR_BUS_FAULT;
    next_record();
    go_idle(4);
    read_all();
    check_value("rule 5 count", '0, regs[5]);
    check_value("rule 6 count", '0, regs[6]);
    check_value("sticky", '0, regs[8]);
    end_test();

    $display("Tests run %0d, passed %0d, failed %0d", passed + failed, passed, failed);
    if (failed == 0 && error_count + local_errors == 0) begin
      $display("Everything OK");
    end else begin
      $display("Something failed");
    end
    $finish;
  end

endmodule

// File: build.f
+incdir+design
design/riscv_priv_pkg.sv
design/umode_mon_pkg.sv
design/rvfi_decode.sv
design/umode_rule_check.sv
design/rule_counter.sv
design/wb_status_regs.sv
design/umode_monitor_top.sv
testbench/umode_checker.sv
testbench/tb_umode_monitor.sv

// File: Bender.yml
package:
  name: umode_monitor

export_include_dirs:
  - design

sources:
  - include_dirs:
      - design
    files:
      - design/riscv_priv_pkg.sv
      - design/umode_mon_pkg.sv
      - design/rvfi_decode.sv
      - design/umode_rule_check.sv
      - design/rule_counter.sv
      - design/wb_status_regs.sv
      - design/umode_monitor_top.sv
  - target: test
    include_dirs:
      - design
    files:
      - testbench/umode_checker.sv
      - testbench/tb_umode_monitor.sv
